// ==== common/vm1_dp_pkg.sv ====
`default_nettype none

// ====================
// datapath command word
// ====================

package vm1_dp_pkg;

    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_CLR  = 4'd1,
        ALU_COM  = 4'd2,
        ALU_INC  = 4'd3,
        ALU_DEC  = 4'd4,
        ALU_NEG  = 4'd5,
        ALU_TST  = 4'd6,
        ALU_INC2 = 4'd7,   // word step for pointers
        ALU_DEC2 = 4'd8
    } alu_op_t;

    typedef enum logic [2:0] {
        CAUSE_NONE     = 3'd0,
        CAUSE_BUSERR   = 3'd1,   // vector 4, also halt
        CAUSE_RESERVED = 3'd2,   // vector 10
        CAUSE_BPT      = 3'd3,
        CAUSE_IOT      = 3'd4
    } trap_cause_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        alu_cc;      // update flags from alu
        logic        reg_write;   // alu result to register file
        logic        save_stat;   // latch pc/ps for the trap frame
        trap_cause_t trap_cause;
    } dp_cmd_t;

endpackage

`default_nettype wire

// ==== common/vm1_ctrl_pkg.sv ====
`default_nettype none

// ====================
// sequencer state and decode
// ====================

package vm1_ctrl_pkg;

    typedef enum logic [5:0] {
        ST_BOOT,
        ST_IF0,
        ST_ID0,
        ST_OF1,
        ST_OF3,
        ST_OF4,
        ST_EX0,
        ST_WB0,
        ST_TRAP_IRQ,
        ST_TRAP_SVC,
        ST_TRAP1,
        ST_TRAP2,
        ST_TRAP3,
        ST_TRAP4
    } seq_state_t;

    // read slots, one per state family that shares the bus
    typedef enum logic [1:0] {
        DI_COM,
        DI_OF4,
        DI_T1,
        DI_T2
    } di_slot_t;

    typedef enum logic [1:0] {
        DO_COM,
        DO_T3,
        DO_T4
    } do_slot_t;

    localparam int DI_SLOTS = 1 << $bits(di_slot_t);
    localparam int DO_SLOTS = 1 << $bits(do_slot_t);

    typedef enum logic [2:0] {
        NOF_NOP,
        NOF_RESET,
        NOF_HALT,
        NOF_BPT,
        NOF_IOT
    } nof_kind_t;

    typedef struct packed {
        logic [1:0]          mode;       // opcode[5:4]
        logic                deferred;   // opcode[3]
        logic                byte_op;
        logic                dst_sppc;   // destination is r6 or r7
        logic                sop;
        logic                nof;
        logic                rsvd;
        nof_kind_t           nof_kind;
        vm1_dp_pkg::alu_op_t alu_op;
    } instr_dec_t;

endpackage

`default_nettype wire

// ==== src/bus_slot_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

// remembers which slot asked for the bus on the last edge, so a reply
// is credited only to the state that actually issued the request
module bus_slot_tracker #(
    parameter type SLOT_T = logic [1:0]
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             ready_i,
    input  logic [(1 << $bits(SLOT_T))-1:0]  req_i,
    output logic [(1 << $bits(SLOT_T))-1:0]  done_o,
    output logic                             busy_o
);

    logic [(1 << $bits(SLOT_T))-1:0] slot_r;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slot_r <= '0;
        end else begin
            slot_r <= req_i;
        end
    end

    assign done_o = slot_r & {$bits(slot_r){ready_i}};
    assign busy_o = |req_i;   // bus request level

endmodule

`default_nettype wire

// ==== decode/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import vm1_ctrl_pkg::*;
    import vm1_dp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [15:0] dbi_i,
    input  logic        load_i,
    output instr_dec_t  dec_o
);

    logic [15:0] ir;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ir <= '0;
        end else if (load_i) begin
            ir <= dbi_i;   // opcode at end of fetch
        end
    end

    // ====================
    // decode
    // ====================

    always_comb begin
        dec_o          = '0;
        dec_o.mode     = ir[5:4];
        dec_o.deferred = ir[3];
        dec_o.byte_op  = ir[15];
        dec_o.dst_sppc = ir[2] & ir[1];
        dec_o.nof_kind = NOF_NOP;
        dec_o.alu_op   = ALU_NONE;

        if (ir[14:9] == 6'o05 && !ir[5]) begin
            // 0050dd..0057dd, only modes 0-3
            dec_o.sop = 1'b1;
            case (ir[8:6])
                3'd0:    dec_o.alu_op = ALU_CLR;
                3'd1:    dec_o.alu_op = ALU_COM;
                3'd2:    dec_o.alu_op = ALU_INC;
                3'd3:    dec_o.alu_op = ALU_DEC;
                3'd4:    dec_o.alu_op = ALU_NEG;
                3'd7:    dec_o.alu_op = ALU_TST;
                default: dec_o.rsvd = 1'b1;   // adc, sbc
            endcase
            if (dec_o.rsvd) begin
                dec_o.sop = 1'b0;
            end
        end else if (ir == 16'o000240) begin
            dec_o.nof = 1'b1;
        end else if (ir == 16'o000000) begin
            dec_o.nof      = 1'b1;
            dec_o.nof_kind = NOF_HALT;
        end else if (ir == 16'o000003) begin
            dec_o.nof      = 1'b1;
            dec_o.nof_kind = NOF_BPT;
        end else if (ir == 16'o000004) begin
            dec_o.nof      = 1'b1;
            dec_o.nof_kind = NOF_IOT;
        end else if (ir == 16'o000005) begin
            dec_o.nof      = 1'b1;
            dec_o.nof_kind = NOF_RESET;
        end else begin
            dec_o.rsvd = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== control/exec_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_cmd_decoder
    import vm1_ctrl_pkg::*;
    import vm1_dp_pkg::*;
(
    input  instr_dec_t dec_i,
    output dp_cmd_t    cmd_o,
    output logic       write_o,
    output logic       fetch_o
);

    logic reg_mode;

    assign reg_mode = (dec_i.mode == 2'b00) && !dec_i.deferred;

    always_comb begin
        cmd_o   = '0;
        write_o = 1'b0;
        fetch_o = 1'b0;

        if (dec_i.rsvd) begin
            cmd_o.trap_cause = CAUSE_RESERVED;
        end else if (dec_i.nof) begin
            case (dec_i.nof_kind)
                NOF_HALT: cmd_o.trap_cause = CAUSE_BUSERR;   // traps to 4 on vm1
                NOF_BPT:  cmd_o.trap_cause = CAUSE_BPT;
                NOF_IOT:  cmd_o.trap_cause = CAUSE_IOT;
                default:  fetch_o = 1'b1;                    // nop, reset
            endcase
        end else if (dec_i.sop) begin
            cmd_o.alu_op = dec_i.alu_op;
            cmd_o.alu_cc = 1'b1;
            if (dec_i.alu_op == ALU_TST) begin
                fetch_o = 1'b1;   // flags only
            end else begin
                write_o = !reg_mode;
            end
        end
    end

endmodule

`default_nettype wire

// ==== control/control_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_sequencer
    import vm1_ctrl_pkg::*;
    import vm1_dp_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                ready_i,
    input  logic                ierror_i,
    input  logic                irq_i,
    input  instr_dec_t          dec_i,
    input  dp_cmd_t             exe_cmd_i,
    input  logic                exe_write_i,
    input  logic                exe_fetch_i,
    input  logic [DI_SLOTS-1:0] di_done_i,
    input  logic [DO_SLOTS-1:0] do_done_i,
    output logic [DI_SLOTS-1:0] di_req_o,
    output logic [DO_SLOTS-1:0] do_req_o,
    output logic                opcode_load_o,
    output logic                byte_o,
    output logic                iako_o,
    output logic                initq_o,
    output logic                ifetch_o,
    output dp_cmd_t             dp_cmd_o
);

    seq_state_t state;
    seq_state_t next;
    logic       mbyte;
    logic       mbyte_r;
    logic       wb_mem_r;   // execute result goes to memory
    logic       inc_byte;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ST_BOOT;
            mbyte_r  <= 1'b0;
            wb_mem_r <= 1'b0;
        end else begin
            state   <= next;
            mbyte_r <= mbyte;
            if (state == ST_EX0) begin
                wb_mem_r <= exe_write_i;
            end
        end
    end

    assign ifetch_o = (state == ST_IF0);
    assign byte_o   = mbyte;

    // pointer step is a byte only for plain byte access through r0-r5
    assign inc_byte = dec_i.byte_op && !(dec_i.deferred || dec_i.dst_sppc);

    // ====================
    // next state
    // ====================

    always_comb begin
        next          = state;
        di_req_o      = '0;
        do_req_o      = '0;
        dp_cmd_o      = '0;
        opcode_load_o = 1'b0;
        initq_o       = 1'b0;
        iako_o        = 1'b0;
        mbyte         = mbyte_r;

        case (state)
            ST_BOOT: begin
                next = ST_IF0;
            end

            ST_IF0: begin
                mbyte = 1'b0;
                if (irq_i) begin
                    next = ST_TRAP_IRQ;
                end else if (ierror_i) begin
                    dp_cmd_o.trap_cause = CAUSE_BUSERR;
                    next                = ST_TRAP_SVC;
                end else if (di_done_i[DI_COM]) begin
                    opcode_load_o = 1'b1;
                    next          = ST_ID0;
                end else begin
                    di_req_o[DI_COM] = 1'b1;
                end
            end

            ST_ID0: begin
                if (dec_i.sop) begin
                    next = ST_OF1;
                end else begin
                    next = ST_EX0;   // no operand or reserved
                end
            end

            ST_OF1: begin
                if (dec_i.mode == 2'b01) begin
                    // autoincrement, step the register now
                    dp_cmd_o.alu_op    = inc_byte ? ALU_INC : ALU_INC2;
                    dp_cmd_o.reg_write = 1'b1;
                    next               = ST_OF3;
                end else if (dec_i.deferred) begin
                    next = ST_OF4;
                end else begin
                    next = ST_EX0;
                end
            end

            ST_OF3: begin
                mbyte = dec_i.deferred ? 1'b0 : dec_i.byte_op;
                if (ierror_i) begin
                    dp_cmd_o.trap_cause = CAUSE_BUSERR;
                    next                = ST_TRAP_SVC;
                end else if (di_done_i[DI_COM]) begin
                    next = dec_i.deferred ? ST_OF4 : ST_EX0;
                end else begin
                    di_req_o[DI_COM] = 1'b1;
                end
            end

            ST_OF4: begin
                mbyte = dec_i.byte_op;
                if (ierror_i) begin
                    dp_cmd_o.trap_cause = CAUSE_BUSERR;
                    next                = ST_TRAP_SVC;
                end else if (di_done_i[DI_OF4]) begin
                    next = ST_EX0;
                end else begin
                    di_req_o[DI_OF4] = 1'b1;
                end
            end

            ST_EX0: begin
                dp_cmd_o = exe_cmd_i;
                if (exe_cmd_i.trap_cause != CAUSE_NONE) begin
                    next = ST_TRAP_SVC;
                end else if (exe_fetch_i) begin
                    initq_o = dec_i.nof && (dec_i.nof_kind == NOF_RESET);
                    next    = ST_IF0;
                end else begin
                    next = ST_WB0;
                end
            end

            ST_WB0: begin
                if (wb_mem_r) begin
                    mbyte = dec_i.byte_op;
                    if (ierror_i) begin
                        dp_cmd_o.trap_cause = CAUSE_BUSERR;
                        next                = ST_TRAP_SVC;
                    end else if (do_done_i[DO_COM]) begin
                        next = irq_i ? ST_TRAP_IRQ : ST_IF0;
                    end else begin
                        do_req_o[DO_COM] = 1'b1;
                    end
                end else begin
                    dp_cmd_o.reg_write = 1'b1;
                    next               = irq_i ? ST_TRAP_IRQ : ST_IF0;
                end
            end

            // it's a trap
            ST_TRAP_IRQ: begin
                iako_o = 1'b1;   // vector read
                mbyte  = 1'b0;
                if (ierror_i) begin
                    dp_cmd_o.trap_cause = CAUSE_BUSERR;
                    next                = ST_TRAP_SVC;
                end else if (di_done_i[DI_COM]) begin
                    dp_cmd_o.save_stat = 1'b1;
                    next               = ST_TRAP1;
                end else begin
                    di_req_o[DI_COM] = 1'b1;
                end
            end

            ST_TRAP_SVC: begin
                dp_cmd_o.save_stat = 1'b1;
                mbyte              = 1'b0;
                next               = ST_TRAP1;
            end

            ST_TRAP1: begin
                mbyte = 1'b0;
                if (ierror_i) begin
                    dp_cmd_o.trap_cause = CAUSE_BUSERR;
                    next                = ST_TRAP_SVC;
                end else if (di_done_i[DI_T1]) begin
                    next = ST_TRAP2;   // new pc
                end else begin
                    di_req_o[DI_T1] = 1'b1;
                end
            end

            ST_TRAP2: begin
                mbyte = 1'b0;
                if (ierror_i) begin
                    dp_cmd_o.trap_cause = CAUSE_BUSERR;
                    next                = ST_TRAP_SVC;
                end else if (di_done_i[DI_T2]) begin
                    next = ST_TRAP3;   // new ps
                end else begin
                    di_req_o[DI_T2] = 1'b1;
                end
            end

            ST_TRAP3: begin
                mbyte = 1'b0;
                if (ierror_i) begin
                    dp_cmd_o.trap_cause = CAUSE_BUSERR;
                    next                = ST_TRAP_SVC;
                end else if (do_done_i[DO_T3]) begin
                    next = ST_TRAP4;   // old ps pushed
                end else begin
                    do_req_o[DO_T3] = 1'b1;
                end
            end

            ST_TRAP4: begin
                mbyte = 1'b0;
                if (ierror_i) begin
                    dp_cmd_o.trap_cause = CAUSE_BUSERR;
                    next                = ST_TRAP_SVC;
                end else if (do_done_i[DO_T4]) begin
                    next = ST_IF0;   // old pc pushed
                end else begin
                    do_req_o[DO_T4] = 1'b1;
                end
            end

            default: begin
                next = ST_BOOT;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== control/control_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_top
    import vm1_ctrl_pkg::*;
    import vm1_dp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [15:0] dbi_i,
    input  logic        ready_i,
    input  logic        ierror_i,
    input  logic        irq_i,
    output logic        dati_o,
    output logic        dato_o,
    output logic        byte_o,
    output logic        iako_o,
    output logic        initq_o,
    output logic        ifetch_o,
    output dp_cmd_t     dp_cmd_o
);

    instr_dec_t          dec;
    dp_cmd_t             exe_cmd;
    logic                exe_write;
    logic                exe_fetch;
    logic                opcode_load;
    logic [DI_SLOTS-1:0] di_req;
    logic [DI_SLOTS-1:0] di_done;
    logic [DO_SLOTS-1:0] do_req;
    logic [DO_SLOTS-1:0] do_done;

    instr_decoder u_instr_decoder (
        .clk     (clk),
        .reset_n (reset_n),
        .dbi_i   (dbi_i),
        .load_i  (opcode_load),
        .dec_o   (dec)
    );

    exec_cmd_decoder u_exec_cmd_decoder (
        .dec_i   (dec),
        .cmd_o   (exe_cmd),
        .write_o (exe_write),
        .fetch_o (exe_fetch)
    );

    // read and write slots tracked apart
    bus_slot_tracker #(.SLOT_T(di_slot_t)) u_di_tracker (
        .clk     (clk),
        .reset_n (reset_n),
        .ready_i (ready_i),
        .req_i   (di_req),
        .done_o  (di_done),
        .busy_o  (dati_o)
    );

    bus_slot_tracker #(.SLOT_T(do_slot_t)) u_do_tracker (
        .clk     (clk),
        .reset_n (reset_n),
        .ready_i (ready_i),
        .req_i   (do_req),
        .done_o  (do_done),
        .busy_o  (dato_o)
    );

    control_sequencer u_control_sequencer (
        .clk           (clk),
        .reset_n       (reset_n),
        .ready_i       (ready_i),
        .ierror_i      (ierror_i),
        .irq_i         (irq_i),
        .dec_i         (dec),
        .exe_cmd_i     (exe_cmd),
        .exe_write_i   (exe_write),
        .exe_fetch_i   (exe_fetch),
        .di_done_i     (di_done),
        .do_done_i     (do_done),
        .di_req_o      (di_req),
        .do_req_o      (do_req),
        .opcode_load_o (opcode_load),
        .byte_o        (byte_o),
        .iako_o        (iako_o),
        .initq_o       (initq_o),
        .ifetch_o      (ifetch_o),
        .dp_cmd_o      (dp_cmd_o)
    );

endmodule

`default_nettype wire

// ==== dv/control_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

// ====================
// bus strobe checks
// ====================

module control_assertions
    import vm1_ctrl_pkg::*;
(
    input logic                clk,
    input logic                reset_n,
    input logic [DI_SLOTS-1:0] di_req_i,
    input logic [DO_SLOTS-1:0] do_req_i,
    input logic                initq_i
);

    // one direction at a time on the bus
    a_rw_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !((|di_req_i) && (|do_req_i)))
        else $error("read and write requested in the same cycle");

    a_initq_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        initq_i |=> !initq_i)
        else $error("bus init held for more than one cycle");

endmodule

bind control_sequencer control_assertions u_control_assertions (
    .clk      (clk),
    .reset_n  (reset_n),
    .di_req_i (di_req_o),
    .do_req_i (do_req_o),
    .initq_i  (initq_o)
);

`default_nettype wire

// ==== dv/tb_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_control
    import vm1_dp_pkg::*;
();

    typedef struct packed {
        logic        is_cmd;
        logic        write;
        logic        bsize;
        logic        iako;
        logic        fetch;
        alu_op_t     alu_op;
        logic        alu_cc;
        logic        reg_write;
        logic        save_stat;
        trap_cause_t cause;
        logic        initq;
    } event_t;

    typedef struct packed {
        logic [15:0] op;
        logic        irq;     // interrupt before this fetch
        logic        abort;   // bus error on first operand read
    } item_t;

    localparam logic [15:0] OP_HALT  = 16'o000000;
    localparam logic [15:0] OP_BPT   = 16'o000003;
    localparam logic [15:0] OP_IOT   = 16'o000004;
    localparam logic [15:0] OP_RESET = 16'o000005;
    localparam logic [15:0] OP_RSVD  = 16'o000007;
    localparam logic [15:0] OP_NOP   = 16'o000240;
    localparam logic [15:0] OP_ADC   = 16'o005500;   // adc is outside the kept set

    logic        clk        = 1'b0;
    logic        reset_n    = 1'b0;
    logic [15:0] dbi        = '0;
    logic        ready      = 1'b0;
    logic        ierror     = 1'b0;
    logic        irq        = 1'b0;
    logic        prog_built = 1'b0;
    logic        dati;
    logic        dato;
    logic        bsize;
    logic        iako;
    logic        initq;
    logic        ifetch;
    dp_cmd_t     dp_cmd;

    item_t       prog[$];
    event_t      exp_q[$];
    int          exp_idx    = 0;
    event_t      last_xfer  = '0;
    int          xfer_count = 0;
    int          xfer_seen  = 0;
    int          fetch_idx  = 0;
    int          seen       = 0;
    int          delay      = 0;
    logic [1:0]  delay_bits = '0;
    logic        irq_taken  = 1'b0;
    logic        abort_taken = 1'b0;
    logic [31:0] lfsr       = 32'hb0ec;
    item_t       cur;

    always #5 clk = ~clk;

    control_top UUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .dbi_i    (dbi),
        .ready_i  (ready),
        .ierror_i (ierror),
        .irq_i    (irq),
        .dati_o   (dati),
        .dato_o   (dato),
        .byte_o   (bsize),
        .iako_o   (iako),
        .initq_o  (initq),
        .ifetch_o (ifetch),
        .dp_cmd_o (dp_cmd)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [15:0] sop_opcode(input logic b, input logic [2:0] f,
                                               input logic [2:0] m, input logic [2:0] r);
        return {b, 6'o05, f, m, r};
    endfunction

    function automatic alu_op_t alu_of(input logic [2:0] f);
        case (f)
            3'd0:    return ALU_CLR;
            3'd1:    return ALU_COM;
            3'd2:    return ALU_INC;
            3'd3:    return ALU_DEC;
            3'd4:    return ALU_NEG;
            default: return ALU_TST;
        endcase
    endfunction

    function automatic event_t xfer_ev(input logic wr, input logic bt, input logic ack);
        event_t e;
        e       = '0;
        e.write = wr;
        e.bsize = bt;
        e.iako  = ack;
        return e;
    endfunction

    function automatic event_t fetch_ev();
        event_t e;
        e       = xfer_ev(1'b0, 1'b0, 1'b0);
        e.fetch = 1'b1;
        return e;
    endfunction

    function automatic event_t cmd_ev(input alu_op_t op, input logic cc, input logic rw,
                                      input logic ss, input trap_cause_t tc, input logic iq);
        event_t e;
        e           = '0;
        e.is_cmd    = 1'b1;
        e.alu_op    = op;
        e.alu_cc    = cc;
        e.reg_write = rw;
        e.save_stat = ss;
        e.cause     = tc;
        e.initq     = iq;
        return e;
    endfunction

    function automatic string describe(input event_t e);
        if (e.is_cmd) begin
            return $sformatf("cmd %s cc=%b rw=%b save=%b cause=%s initq=%b", e.alu_op.name(),
                             e.alu_cc, e.reg_write, e.save_stat, e.cause.name(), e.initq);
        end
        return $sformatf("%s %s iako=%b fetch=%b", e.write ? "write" : "read",
                         e.bsize ? "byte" : "word", e.iako, e.fetch);
    endfunction

    function automatic item_t item_at(input int i);
        if (i < prog.size()) begin
            return prog[i];
        end
        return '{OP_NOP, 1'b0, 1'b0};
    endfunction

    // ====================
    // reference model
    // ====================

    function automatic void expect_trap_frame();
        exp_q.push_back(cmd_ev(ALU_NONE, 1'b0, 1'b0, 1'b1, CAUSE_NONE, 1'b0));
        exp_q.push_back(xfer_ev(1'b0, 1'b0, 1'b0));   // vector
        exp_q.push_back(xfer_ev(1'b0, 1'b0, 1'b0));   // ps
        exp_q.push_back(xfer_ev(1'b1, 1'b0, 1'b0));
        exp_q.push_back(xfer_ev(1'b1, 1'b0, 1'b0));
    endfunction

    function automatic void expect_instr(input item_t it);
        logic [15:0] op;
        logic        bt;
        logic [2:0]  m;
        logic        sppc;
        logic        sop;
        alu_op_t     alu;
        trap_cause_t tc;
        op   = it.op;
        bt   = op[15];
        m    = op[5:3];
        sppc = (op[2:1] == 2'b11);
        sop  = (op[14:9] == 6'o05) && !op[5] && (op[8:6] != 3'd5) && (op[8:6] != 3'd6);
        alu  = alu_of(op[8:6]);
        if (it.irq) begin
            exp_q.push_back(xfer_ev(1'b0, 1'b0, 1'b1));
            expect_trap_frame();
        end
        exp_q.push_back(fetch_ev());   // opcode fetch
        if (sop) begin
            if (m[1]) begin
                // byte step only for plain byte access through r0-r5
                exp_q.push_back(cmd_ev((bt && !m[0] && !sppc) ? ALU_INC : ALU_INC2,
                                       1'b0, 1'b1, 1'b0, CAUSE_NONE, 1'b0));
            end
            if (m != 3'd0) begin
                if (it.abort) begin
                    exp_q.push_back(cmd_ev(ALU_NONE, 1'b0, 1'b0, 1'b0, CAUSE_BUSERR, 1'b0));
                    expect_trap_frame();
                    return;
                end
                if (m == 3'd3) begin
                    exp_q.push_back(xfer_ev(1'b0, 1'b0, 1'b0));   // pointer
                end
                exp_q.push_back(xfer_ev(1'b0, bt, 1'b0));
            end
            exp_q.push_back(cmd_ev(alu, 1'b1, 1'b0, 1'b0, CAUSE_NONE, 1'b0));
            if (alu != ALU_TST) begin
                if (m == 3'd0) begin
                    exp_q.push_back(cmd_ev(ALU_NONE, 1'b0, 1'b1, 1'b0, CAUSE_NONE, 1'b0));
                end else begin
                    exp_q.push_back(xfer_ev(1'b1, bt, 1'b0));
                end
            end
        end else if (op == OP_RESET) begin
            exp_q.push_back(cmd_ev(ALU_NONE, 1'b0, 1'b0, 1'b0, CAUSE_NONE, 1'b1));
        end else if (op != OP_NOP) begin
            case (op)
                OP_HALT: tc = CAUSE_BUSERR;
                OP_BPT:  tc = CAUSE_BPT;
                OP_IOT:  tc = CAUSE_IOT;
                default: tc = CAUSE_RESERVED;
            endcase
            exp_q.push_back(cmd_ev(ALU_NONE, 1'b0, 1'b0, 1'b0, tc, 1'b0));
            expect_trap_frame();
        end
    endfunction

    function automatic void build_program();
        logic [2:0] codes [6];
        codes = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd7};
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k < 6; k++) begin
                prog.push_back('{sop_opcode(b[0], codes[k], 3'd0, codes[k]), 1'b0, 1'b0});
            end
        end
        for (int m = 1; m < 4; m++) begin
            for (int b = 0; b < 2; b++) begin
                for (int k = 0; k < 2; k++) begin
                    for (int r = 0; r < 2; r++) begin
                        prog.push_back('{sop_opcode(b[0], k[0] ? 3'd7 : 3'd0, m[2:0],
                                                    r[0] ? 3'd6 : 3'd3), 1'b0, 1'b0});
                    end
                end
            end
        end
        prog.push_back('{OP_BPT, 1'b0, 1'b0});
        prog.push_back('{OP_IOT, 1'b0, 1'b0});
        prog.push_back('{OP_HALT, 1'b0, 1'b0});
        prog.push_back('{OP_RSVD, 1'b0, 1'b0});
        prog.push_back('{OP_ADC, 1'b0, 1'b0});
        prog.push_back('{OP_NOP, 1'b1, 1'b0});
        prog.push_back('{sop_opcode(1'b0, 3'd2, 3'd0, 3'd1), 1'b1, 1'b0});
        prog.push_back('{sop_opcode(1'b0, 3'd0, 3'd1, 3'd1), 1'b0, 1'b1});
        prog.push_back('{sop_opcode(1'b1, 3'd0, 3'd2, 3'd2), 1'b0, 1'b1});
        prog.push_back('{sop_opcode(1'b0, 3'd7, 3'd3, 3'd4), 1'b0, 1'b1});
        prog.push_back('{OP_RESET, 1'b0, 1'b0});
        prog.push_back('{OP_NOP, 1'b0, 1'b0});
        prog.push_back('{OP_RESET, 1'b0, 1'b0});
        prog.push_back('{OP_NOP, 1'b0, 1'b0});   // closing fetch
    endfunction

    task automatic end_with_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_event(input event_t act);
        event_t exp;
        assert (exp_idx < exp_q.size()) else begin
            $display("the DUT showed %s at %0t ns after the last expected event",
                     describe(act), $time);
            end_with_failure();
        end
        exp = exp_q[exp_idx];
        assert (act == exp) else begin
            $display("ERROR: %0t ns event %0d expected %s got %s", $time, exp_idx,
                     describe(exp), describe(act));
            end_with_failure();
        end
        exp_idx = exp_idx + 1;
    endtask

    // ====================
    // bus responder
    // ====================

    always @(negedge clk) begin
        cur = item_at(fetch_idx);
        if (!reset_n) begin
            ready  = 1'b0;
            ierror = 1'b0;
            irq    = 1'b0;
            seen   = 0;
        end else if (ready || ierror) begin
            ready  = 1'b0;   // strobes last one cycle
            ierror = 1'b0;
            seen   = 0;
        end else if (dati || dato) begin
            if (ifetch && cur.irq && !irq_taken) begin
                irq       = 1'b1;
                irq_taken = 1'b1;
                seen      = 0;
            end else if (seen == 0) begin
                delay_bits[0] = lfsr[0];
                lfsr          = lfsr_next(lfsr);
                delay_bits[1] = lfsr[0];
                lfsr          = lfsr_next(lfsr);
                delay         = {30'd0, delay_bits};
                seen          = 1;
            end else if (seen <= delay) begin
                seen = seen + 1;
            end else if (dati && !ifetch && !iako && fetch_idx > 0
                         && prog[fetch_idx-1].abort && !abort_taken) begin
                ierror      = 1'b1;
                abort_taken = 1'b1;
            end else begin
                last_xfer       = xfer_ev(dato, bsize, iako);
                last_xfer.fetch = ifetch;
                xfer_count      = xfer_count + 1;
                if (ifetch) begin
                    dbi         = cur.op;
                    fetch_idx   = fetch_idx + 1;
                    irq_taken   = 1'b0;
                    abort_taken = 1'b0;
                end
                if (iako) begin
                    irq = 1'b0;   // vector taken
                end
                ready = 1'b1;
            end
        end
    end

    // monitor and compare
    always @(posedge clk) begin
        if (reset_n) begin
            if (xfer_count != xfer_seen) begin
                xfer_seen = xfer_count;
                compare_event(last_xfer);
            end
            if (dp_cmd != '0 || initq) begin
                compare_event(cmd_ev(dp_cmd.alu_op, dp_cmd.alu_cc, dp_cmd.reg_write,
                                     dp_cmd.save_stat, dp_cmd.trap_cause, initq));
            end
        end
    end

    initial begin
        build_program();
        foreach (prog[i]) begin
            expect_instr(prog[i]);
        end
        prog_built = 1'b1;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        wait (exp_idx == exp_q.size());
        // closing nop runs on until the next fetch request
        @(negedge clk);
        while (!(ifetch && dati)) begin
            @(negedge clk);
        end
        $display("TEST PASS");
        $finish;
    end

    // 60 cycles allowed per instruction
    initial begin
        wait (prog_built);
        #(prog.size() * 60 * 10 + 100);
        $display("watchdog expired before the instruction stream finished");
        end_with_failure();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/vm1_dp_pkg.sv
common/vm1_ctrl_pkg.sv
src/bus_slot_tracker.sv
decode/instr_decoder.sv
control/exec_cmd_decoder.sv
control/control_sequencer.sv
control/control_top.sv
dv/control_assertions.sv
dv/tb_control.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_control -f tb.f \
    --Mdir obj_dir -o tb_control_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_control_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
